/* flist.f */
+incdir+include
verilog/mem_pkg.sv
verilog/line_ram.sv
verilog/dram_cache.sv
verilog/backing_mem.sv
verilog/lsu_align.sv
verilog/cache_ctrl.sv
verilog/mem_top.sv
sim/tb_mem_top.sv

/* include/mem_cfg.svh */
// sizes and timing of the data memory port, included by the package and the sized RTL
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// core side
`define MEM_ADDR_W        32
`define MEM_WORD_W        32

// line geometry
`define MEM_LINE_W        128
`define MEM_LINE_BYTES    16
`define MEM_OFFSET_W      4

// direct-mapped cache depth in lines
`define MEM_CACHE_ENTRIES 16

// backing store, 256 lines of 16 bytes
// upper address bits wrap around
`define MEM_LINE_COUNT    256

// backing access latency in cycles, at least 2
`define MEM_DELAY         6

`endif

/* run.sh */
#!/usr/bin/env bash
# build and run the memory port testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f flist.f --top-module tb_mem_top -o tb_mem_top \
    || { echo "build failed"; exit 1; }

./obj_dir/tb_mem_top > sim.log 2>&1 ; cat sim.log

grep -q "^All checks passed$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sim/tb_mem_top.sv */
// directed testbench of the data memory port, run as the simulation top against a byte model
`default_nettype none

module tb_mem_top;
    timeunit 1ns;
    timeprecision 1ps;

    import mem_pkg::*;

    localparam int BUSY_LIMIT = 200;

    logic                    CLK;
    logic                    i_rrst_x;
    logic                    i_rd_en;
    logic                    i_wr_en;
    mem_cmd_t                i_cmd;
    logic [31:0]             o_rdata;
    logic                    o_busy;

    // byte model of the 4 KiB backing store
    logic [7:0]              model [0:4095];
    int                      errors;
    int                      checks;
    int                      seed;

    mem_top DUT (
        .CLK      (CLK),
        .i_rrst_x (i_rrst_x),
        .i_rd_en  (i_rd_en),
        .i_wr_en  (i_wr_en),
        .i_cmd    (i_cmd),
        .o_rdata  (o_rdata),
        .o_busy   (o_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // sample at the falling edge, where outputs are settled
    task automatic wait_idle(output int cycles);
        int n;
        n = 0;
        @(negedge CLK);
        while (o_busy && n < BUSY_LIMIT) begin
            @(negedge CLK);
            n++;
        end
        cycles = n;
        if (o_busy) begin
            $display("timeout, o_busy still high after %0d cycles at %0t ns", n, $time);
            $display("Checks failed");
            $finish;
        end
    endtask

    task automatic issue(input logic rd, input mem_cmd_t cmd);
        @(posedge CLK);
        i_rd_en <= rd;
        i_wr_en <= !rd;
        i_cmd   <= cmd;
        @(posedge CLK);
        i_rd_en <= 1'b0;
        i_wr_en <= 1'b0;
    endtask

    task automatic store(input logic [31:0] addr, input mem_size_e size,
                         input logic [31:0] data);
        mem_cmd_t cmd;
        int       cycles;
        cmd = '{size: size, is_unsigned: 1'b0, addr: addr, wdata: data};
        issue(1'b0, cmd);
        wait_idle(cycles);
        model[addr[11:0]] = data[7:0];
        if (size != size_byte) begin
            model[addr[11:0] + 12'd1] = data[15:8];
        end
        if (size == size_word) begin
            model[addr[11:0] + 12'd2] = data[23:16];
            model[addr[11:0] + 12'd3] = data[31:24];
        end
    endtask

    task automatic load(input logic [31:0] addr, input mem_size_e size,
                        input logic uns, output logic [31:0] data, output int cycles);
        mem_cmd_t cmd;
        cmd = '{size: size, is_unsigned: uns, addr: addr, wdata: 32'h0};
        issue(1'b1, cmd);
        wait_idle(cycles);
        data = o_rdata;
    endtask

    // expected load result from the model and the size rule
    function automatic logic [31:0] expected(input logic [31:0] addr, input mem_size_e size,
                                             input logic uns);
        logic [11:0] a;
        logic [31:0] w;
        a = addr[11:0];
        w = {model[a + 12'd3], model[a + 12'd2], model[a + 12'd1], model[a]};
        if (size == size_byte) begin
            return uns ? {24'h0, w[7:0]} : {{24{w[7]}}, w[7:0]};
        end else if (size == size_half) begin
            return uns ? {16'h0, w[15:0]} : {{16{w[15]}}, w[15:0]};
        end
        return w;
    endfunction

    task automatic load_check(input string what, input logic [31:0] addr,
                              input mem_size_e size, input logic uns);
        logic [31:0] data;
        int          cycles;
        load(addr, size, uns, data, cycles);
        check_value(what, data, expected(addr, size, uns));
    endtask

    task automatic report(input string name, input int errs_before);
        $display("%s finished with %0d errors", name, errors - errs_before);
    endtask

    task automatic reset_test();
        int n;
        int e0;
        e0 = errors;
        n = 0;
        @(negedge CLK);
        while (o_busy && n < BUSY_LIMIT) begin
            @(negedge CLK);
            n++;
        end
        if (o_busy) begin
            $display("timeout, o_busy did not fall after reset");
            $display("Checks failed");
            $finish;
        end
        check_value("o_rdata after reset", o_rdata, 32'h0);
        report("reset", e0);
    endtask

    task automatic word_test();
        logic [31:0] data;
        int          miss_cycles;
        int          hit_cycles;
        int          e0;
        e0 = errors;
        store(32'h0000_0124, size_word, 32'hcafe_1234);
        load(32'h0000_0124, size_word, 1'b0, data, miss_cycles);
        check_value("word load after store", data, 32'hcafe_1234);
        load(32'h0000_0124, size_word, 1'b0, data, hit_cycles);
        check_value("second word load", data, 32'hcafe_1234);
        check_value("hit faster than miss", 32'(hit_cycles < miss_cycles), 32'h1);
        report("word store and load", e0);
    endtask

    task automatic subword_test();
        int e0;
        e0 = errors;
        store(32'h0000_0100, size_word, 32'h1122_3344);
        for (int off = 0; off < 4; off++) begin
            store(32'h0000_0100 + off, size_byte, $random(seed));
            load_check("word after byte store", 32'h0000_0100, size_word, 1'b0);
        end
        for (int off = 0; off < 4; off += 2) begin
            store(32'h0000_0100 + off, size_half, $random(seed));
            load_check("word after half store", 32'h0000_0100, size_word, 1'b0);
        end
        report("byte and half stores", e0);
    endtask

    task automatic extend_test();
        logic [31:0] data;
        int          cycles;
        int          e0;
        e0 = errors;
        store(32'h0000_0200, size_word, 32'h8cf0_a59a);
        load(32'h0000_0200, size_byte, 1'b0, data, cycles);
        check_value("signed byte", data, 32'hffff_ff9a);
        load(32'h0000_0200, size_byte, 1'b1, data, cycles);
        check_value("unsigned byte", data, 32'h0000_009a);
        load(32'h0000_0201, size_byte, 1'b0, data, cycles);
        check_value("signed byte at offset 1", data, 32'hffff_ffa5);
        load(32'h0000_0202, size_half, 1'b0, data, cycles);
        check_value("signed half", data, 32'hffff_8cf0);
        load(32'h0000_0202, size_half, 1'b1, data, cycles);
        check_value("unsigned half", data, 32'h0000_8cf0);
        load(32'h0000_0200, size_half, 1'b0, data, cycles);
        check_value("signed half at offset 0", data, 32'hffff_a59a);
        report("sign and zero extension", e0);
    endtask

    // index bits 7:4 equal, tags differ
    task automatic conflict_test();
        int e0;
        e0 = errors;
        store(32'h0000_0340, size_word, 32'haaaa_0001);
        store(32'h0000_0740, size_word, 32'hbbbb_0002);
        load_check("line A first load", 32'h0000_0340, size_word, 1'b0);
        load_check("line B evicts A", 32'h0000_0740, size_word, 1'b0);
        store(32'h0000_0344, size_word, 32'haaaa_0003);
        load_check("line A after store", 32'h0000_0344, size_word, 1'b0);
        load_check("line B reload", 32'h0000_0740, size_word, 1'b0);
        store(32'h0000_0742, size_half, 32'h0000_9876);
        load_check("line B after store", 32'h0000_0740, size_word, 1'b0);
        load_check("line A reload", 32'h0000_0340, size_word, 1'b0);
        report("same index conflict", e0);
    endtask

    task automatic random_test();
        logic [31:0] addr;
        mem_size_e   ssize;
        mem_size_e   lsize;
        int          e0;
        e0 = errors;
        for (int i = 0; i < 40; i++) begin
            addr  = $random(seed) & 32'h0000_0fff;
            ssize = mem_size_e'(($random(seed) & 32'h7fff_ffff) % 3);
            lsize = mem_size_e'(($random(seed) & 32'h7fff_ffff) % 3);
            if (ssize == size_half) addr[0] = 1'b0;
            if (ssize == size_word) addr[1:0] = 2'b00;
            store(addr, ssize, $random(seed));
            if (lsize == size_half) addr[0] = 1'b0;
            if (lsize == size_word) addr[1:0] = 2'b00;
            load_check("random load", addr, lsize, 1'($random(seed)));
        end
        report("random stores and loads", e0);
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        seed     = 32'h5e35;
        i_rrst_x = 1'b0;
        i_rd_en  = 1'b0;
        i_wr_en  = 1'b0;
        i_cmd    = '0;
        for (int i = 0; i < 4096; i++) begin
            model[i] = 8'h00;
        end
        repeat (4) @(posedge CLK);
        i_rrst_x <= 1'b1;

        reset_test();
        word_test();
        subword_test();
        extend_test();
        conflict_test();
        random_test();

        $display("%0d checks run, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/backing_mem.sv */
// backing line memory with byte strobes and fixed latency, req/ack slave of the cache controller
`default_nettype none

`include "mem_cfg.svh"

module backing_mem (
    input  wire                     CLK,
    input  wire                     i_rrst_x,
    input  wire                     i_req,
    input  mem_pkg::line_req_t      i_cmd,
    output logic                    o_ack,
    output logic [`MEM_LINE_W-1:0]  o_line
);
    localparam int IDX_W = $clog2(`MEM_LINE_COUNT);
    localparam int CNT_W = $clog2(`MEM_DELAY);

    logic [`MEM_LINE_W-1:0]     r_mem [0:`MEM_LINE_COUNT-1];
    logic [CNT_W-1:0]           r_cnt;
    logic                       r_ack;
    logic [`MEM_LINE_W-1:0]     r_line;

    logic [IDX_W-1:0]           w_idx;
    logic [`MEM_LINE_BYTES-1:0] w_strb;
    logic [`MEM_LINE_W-1:0]     w_wline;
    logic                       w_fire;

    initial begin
        for (int i = 0; i < `MEM_LINE_COUNT; i++) begin
            r_mem[i] = '0;
        end
    end

    // high line address bits wrap
    assign w_idx = i_cmd.line_addr[IDX_W-1:0];

    // word mask placed at the selected word of the line
    assign w_strb  = `MEM_LINE_BYTES'(i_cmd.wmask) << {i_cmd.word_sel, 2'b00};
    assign w_wline = {(`MEM_LINE_W / `MEM_WORD_W){i_cmd.wdata}};

    // last cycle of the access delay
    assign w_fire = i_req && !r_ack && (r_cnt == CNT_W'(`MEM_DELAY - 1));

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_cnt <= '0;
            r_ack <= 1'b0;
        end else if (r_ack) begin
            // four-phase, hold ack until req is gone
            if (!i_req) begin
                r_ack <= 1'b0;
            end
        end else if (w_fire) begin
            r_cnt <= '0;
            r_ack <= 1'b1;
        end else if (i_req) begin
            r_cnt <= r_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (w_fire) begin
            if (i_cmd.we) begin
                for (int b = 0; b < `MEM_LINE_BYTES; b++) begin
                    if (w_strb[b]) begin
                        r_mem[w_idx][b*8 +: 8] <= w_wline[b*8 +: 8];
                    end
                end
            end else begin
                r_line <= r_mem[w_idx];
            end
        end
    end

    assign o_ack  = r_ack;
    assign o_line = r_line;

endmodule

`default_nettype wire

/* verilog/cache_ctrl.sv */
// cache controller FSM, handles lookup, miss fill and write-through with the req/ack master
`default_nettype none

`include "mem_cfg.svh"

module cache_ctrl (
    input  wire                     CLK,
    input  wire                     i_rrst_x,
    input  wire                     i_rd,
    input  wire                     i_we,
    input  mem_pkg::line_req_t      i_req,
    output logic [`MEM_LINE_W-1:0]  o_line,
    output logic                    o_done,
    output logic                    o_busy,
    output logic                    o_mem_req,
    output mem_pkg::line_req_t      o_mem_cmd,
    input  wire                     i_mem_ack,
    input  wire  [`MEM_LINE_W-1:0]  i_mem_line
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(`MEM_CACHE_ENTRIES);
    localparam int TAG_W = `MEM_ADDR_W - `MEM_OFFSET_W - IDX_W;

    ctrl_state_e             r_state;
    logic                    r_mem_req;
    line_req_t               r_mem_cmd;

    logic [IDX_W-1:0]        w_idx;
    logic [TAG_W-1:0]        w_tag;
    logic                    w_ack_seen;
    logic                    w_fill;
    logic                    w_inval;
    logic [`MEM_LINE_W-1:0]  w_cache_line;
    logic                    w_hit;
    logic                    w_sweeping;

    // the request is stable from idle on, so it indexes the cache directly
    assign {w_tag, w_idx} = i_req.line_addr;

    assign w_ack_seen = r_mem_req && i_mem_ack;
    assign w_fill     = (r_state == st_fill) && w_ack_seen;
    assign w_inval    = (r_state == st_write) && w_ack_seen;

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_state   <= st_idle;
            r_mem_req <= 1'b0;
        end else begin
            case (r_state)
                st_idle: begin
                    if (i_rd) begin
                        r_state <= st_lookup;
                    end else if (i_we) begin
                        r_state   <= st_write;
                        r_mem_req <= 1'b1;
                    end
                end
                st_lookup: begin
                    if (w_hit) begin
                        r_state <= st_idle;
                    end else begin
                        r_state   <= st_fill;
                        r_mem_req <= 1'b1;
                    end
                end
                // ack drops one cycle after req, before any new req can rise
                st_fill, st_write: begin
                    if (w_ack_seen) begin
                        r_state   <= st_idle;
                        r_mem_req <= 1'b0;
                    end
                end
                default: r_state <= st_idle;
            endcase
        end
    end

    // command frozen for the whole handshake
    always_ff @(posedge CLK) begin
        if (!r_mem_req) begin
            r_mem_cmd <= i_req;
        end
    end

    dram_cache u_cache (
        .CLK        (CLK),
        .i_rrst_x   (i_rrst_x),
        .i_idx      (w_idx),
        .i_tag      (w_tag),
        .i_fill     (w_fill),
        .i_inval    (w_inval),
        .i_line     (i_mem_line),
        .o_line     (w_cache_line),
        .o_hit      (w_hit),
        .o_sweeping (w_sweeping)
    );

    // fill returns the fresh line, lookup the stored one
    assign o_line = (r_state == st_fill) ? i_mem_line : w_cache_line;
    assign o_done = ((r_state == st_lookup) && w_hit) || w_ack_seen;

    // pending covers the cycle between the core pulse and leaving idle
    assign o_busy    = (r_state != st_idle) || i_rd || i_we || w_sweeping;
    assign o_mem_req = r_mem_req;
    assign o_mem_cmd = r_mem_cmd;

endmodule

`default_nettype wire

/* verilog/dram_cache.sv */
// direct-mapped line cache store with tag compare and the valid-bit sweep after reset
`default_nettype none

`include "mem_cfg.svh"

module dram_cache (
    input  wire                                                       CLK,
    input  wire                                                       i_rrst_x,
    input  wire  [$clog2(`MEM_CACHE_ENTRIES)-1:0]                     i_idx,
    input  wire  [`MEM_ADDR_W-`MEM_OFFSET_W-$clog2(`MEM_CACHE_ENTRIES)-1:0] i_tag,
    input  wire                                                       i_fill,
    input  wire                                                       i_inval,
    input  wire  [`MEM_LINE_W-1:0]                                    i_line,
    output logic [`MEM_LINE_W-1:0]                                    o_line,
    output logic                                                      o_hit,
    output logic                                                      o_sweeping
);
    localparam int ENTRIES = `MEM_CACHE_ENTRIES;
    localparam int IDX_W   = $clog2(ENTRIES);
    localparam int TAG_W   = `MEM_ADDR_W - `MEM_OFFSET_W - IDX_W;
    localparam int ENT_W   = 1 + TAG_W + `MEM_LINE_W;

    logic [IDX_W-1:0]  r_sweep_idx;
    logic              r_sweeping;
    logic [TAG_W-1:0]  r_tag;

    logic              w_we;
    logic [IDX_W-1:0]  w_addr;
    logic [ENT_W-1:0]  w_wdata;
    logic [ENT_W-1:0]  w_rdata;
    logic              w_valid;
    logic [TAG_W-1:0]  w_mtag;

    // walk all indices once, writing empty entries
    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_sweeping  <= 1'b1;
            r_sweep_idx <= '0;
        end else if (r_sweeping) begin
            r_sweep_idx <= r_sweep_idx + 1'b1;
            if (r_sweep_idx == IDX_W'(ENTRIES - 1)) begin
                r_sweeping <= 1'b0;
            end
        end
    end

    // tag of the lookup, compared when the RAM output arrives
    always_ff @(posedge CLK) begin
        r_tag <= i_tag;
    end

    assign w_we    = i_fill || i_inval || r_sweeping;
    assign w_addr  = r_sweeping ? r_sweep_idx : i_idx;
    assign w_wdata = i_fill ? {1'b1, i_tag, i_line} : '0;

    line_ram #(.WIDTH(ENT_W), .ENTRIES(ENTRIES)) u_ram (
        .CLK     (CLK),
        .i_we    (w_we),
        .i_addr  (w_addr),
        .i_wdata (w_wdata),
        .o_rdata (w_rdata)
    );

    assign {w_valid, w_mtag, o_line} = w_rdata;
    assign o_hit      = w_valid && (w_mtag == r_tag);
    assign o_sweeping = r_sweeping;

endmodule

`default_nettype wire

/* verilog/line_ram.sv */
// single-port RAM with registered read-first output, storage array of the cache
`default_nettype none

module line_ram #(
    parameter int WIDTH   = 32,
    parameter int ENTRIES = 256
) (
    input  wire                        CLK,
    input  wire                        i_we,
    input  wire  [$clog2(ENTRIES)-1:0] i_addr,
    input  wire  [WIDTH-1:0]           i_wdata,
    output logic [WIDTH-1:0]           o_rdata
);
    logic [WIDTH-1:0] r_mem [0:ENTRIES-1];

    // read returns the old contents on a write cycle
    always_ff @(posedge CLK) begin
        if (i_we) begin
            r_mem[i_addr] <= i_wdata;
        end
        o_rdata <= r_mem[i_addr];
    end

endmodule

`default_nettype wire

/* verilog/lsu_align.sv */
// load/store aligner, registers the core request and shapes store data and load results
`default_nettype none

`include "mem_cfg.svh"

module lsu_align (
    input  wire                     CLK,
    input  wire                     i_rrst_x,
    input  wire                     i_rd_en,
    input  wire                     i_wr_en,
    input  mem_pkg::mem_cmd_t       i_cmd,
    input  wire  [`MEM_LINE_W-1:0]  i_line,
    input  wire                     i_done,
    output logic                    o_rd,
    output logic                    o_we,
    output mem_pkg::line_req_t      o_req,
    output logic [`MEM_WORD_W-1:0]  o_rdata
);
    import mem_pkg::*;

    mem_cmd_t                r_cmd;
    logic                    r_rd;
    logic                    r_we;
    logic                    r_store;
    logic [`MEM_WORD_W-1:0]  r_rdata;

    logic [3:0]              w_mask;
    logic [`MEM_WORD_W-1:0]  w_wdata;
    logic [`MEM_LINE_W-1:0]  w_shift;
    logic [`MEM_WORD_W-1:0]  w_word;
    logic                    w_sign;
    logic [`MEM_WORD_W-1:0]  w_load;

    // request payload, held until the next access
    always_ff @(posedge CLK) begin
        if (i_rd_en || i_wr_en) begin
            r_cmd <= i_cmd;
        end
    end

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_rd    <= 1'b0;
            r_we    <= 1'b0;
            r_store <= 1'b0;
        end else begin
            r_rd <= i_rd_en;
            r_we <= i_wr_en;
            if (i_wr_en) begin
                r_store <= 1'b1;
            end else if (i_rd_en) begin
                r_store <= 1'b0;
            end
        end
    end

    // byte enables and lane replication of store data
    always_comb begin
        case (r_cmd.size)
            size_byte: begin
                w_mask  = 4'b0001 << r_cmd.addr[1:0];
                w_wdata = {4{r_cmd.wdata[7:0]}};
            end
            size_half: begin
                w_mask  = 4'b0011 << {r_cmd.addr[1], 1'b0};
                w_wdata = {2{r_cmd.wdata[15:0]}};
            end
            default: begin
                w_mask  = 4'b1111;
                w_wdata = r_cmd.wdata;
            end
        endcase
    end

    always_comb begin
        o_req.we        = r_store;
        o_req.line_addr = r_cmd.addr[`MEM_ADDR_W-1:`MEM_OFFSET_W];
        o_req.word_sel  = r_cmd.addr[`MEM_OFFSET_W-1:2];
        o_req.wmask     = w_mask;
        o_req.wdata     = w_wdata;
    end

    // load path: move the addressed byte to bit 0, then extend
    assign w_shift = i_line >> {r_cmd.addr[`MEM_OFFSET_W-1:0], 3'b000};
    assign w_word  = w_shift[`MEM_WORD_W-1:0];
    assign w_sign  = !r_cmd.is_unsigned;

    always_comb begin
        case (r_cmd.size)
            size_byte: w_load = {{24{w_word[7] & w_sign}}, w_word[7:0]};
            size_half: w_load = {{16{w_word[15] & w_sign}}, w_word[15:0]};
            default:   w_load = w_word;
        endcase
    end

    // result stays until the next load finishes
    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_rdata <= '0;
        end else if (i_done && !r_store) begin
            r_rdata <= w_load;
        end
    end

    assign o_rd    = r_rd;
    assign o_we    = r_we;
    assign o_rdata = r_rdata;

endmodule

`default_nettype wire

/* verilog/mem_pkg.sv */
// shared enums and request structs of the memory port, used by the RTL and the testbench
`default_nettype none

`include "mem_cfg.svh"

package mem_pkg;

    // access size of a core load or store
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } mem_size_e;

    // core request as driven with i_rd_en / i_wr_en
    typedef struct packed {
        mem_size_e               size;
        logic                    is_unsigned;
        logic [`MEM_ADDR_W-1:0]  addr;
        logic [`MEM_WORD_W-1:0]  wdata;
    } mem_cmd_t;

    // cache controller states
    typedef enum logic [1:0] {
        st_idle   = 2'b00,
        st_lookup = 2'b01,
        st_fill   = 2'b10,
        st_write  = 2'b11
    } ctrl_state_e;

    // line request toward the backing memory
    // mask and data are already placed for the selected word
    typedef struct packed {
        logic                                  we;
        logic [`MEM_ADDR_W-`MEM_OFFSET_W-1:0]  line_addr;
        logic [`MEM_OFFSET_W-3:0]              word_sel;
        logic [`MEM_WORD_W/8-1:0]              wmask;
        logic [`MEM_WORD_W-1:0]                wdata;
    } line_req_t;

endpackage

`default_nettype wire

/* verilog/mem_top.sv */
// top of the data memory port, connects the core-side aligner, the cache and the backing memory
`default_nettype none

`include "mem_cfg.svh"

module mem_top (
    input  wire                     CLK,
    input  wire                     i_rrst_x,
    input  wire                     i_rd_en,
    input  wire                     i_wr_en,
    input  mem_pkg::mem_cmd_t       i_cmd,
    output logic [`MEM_WORD_W-1:0]  o_rdata,
    output logic                    o_busy
);
    import mem_pkg::*;

    // aligner to controller
    logic                    w_rd;
    logic                    w_we;
    line_req_t               w_req;
    logic [`MEM_LINE_W-1:0]  w_line;
    logic                    w_done;

    // controller to backing memory
    logic                    w_mem_req;
    line_req_t               w_mem_cmd;
    logic                    w_mem_ack;
    logic [`MEM_LINE_W-1:0]  w_mem_line;

    lsu_align u_lsu (
        .CLK      (CLK),
        .i_rrst_x (i_rrst_x),
        .i_rd_en  (i_rd_en),
        .i_wr_en  (i_wr_en),
        .i_cmd    (i_cmd),
        .i_line   (w_line),
        .i_done   (w_done),
        .o_rd     (w_rd),
        .o_we     (w_we),
        .o_req    (w_req),
        .o_rdata  (o_rdata)
    );

    cache_ctrl u_ctrl (
        .CLK        (CLK),
        .i_rrst_x   (i_rrst_x),
        .i_rd       (w_rd),
        .i_we       (w_we),
        .i_req      (w_req),
        .o_line     (w_line),
        .o_done     (w_done),
        .o_busy     (o_busy),
        .o_mem_req  (w_mem_req),
        .o_mem_cmd  (w_mem_cmd),
        .i_mem_ack  (w_mem_ack),
        .i_mem_line (w_mem_line)
    );

    backing_mem u_mem (
        .CLK      (CLK),
        .i_rrst_x (i_rrst_x),
        .i_req    (w_mem_req),
        .i_cmd    (w_mem_cmd),
        .o_ack    (w_mem_ack),
        .o_line   (w_mem_line)
    );

endmodule

`default_nettype wire
